// File: hdl/mask_beat_gen.sv
module mask_beat_gen import mask_lane_pkg::*; import mask_insn_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  mask_issue_if.gen                issue,
  // Operand channels A and M
  input  elen_t    [NrLanes-1:0]   opnd_a_i,
  input  elen_t    [NrLanes-1:0]   opnd_m_i,
  input  logic     [NrLanes-1:0]   opnd_a_valid_i,
  input  logic     [NrLanes-1:0]   opnd_m_valid_i,
  output logic     [NrLanes-1:0]   opnd_ready_o,
  // Result queue side
  input  logic                     queue_full_i,
  output logic                     push_o,
  output payload_t [NrLanes-1:0]   payload_o
);

  // Bytes and bits written by one full beat
  localparam int unsigned BeatBytes = NrLanes * StrbWidth;
  localparam int unsigned BeatBits  = NrLanes * ElenWidth;

  logic                beat_join;
  elen_t [NrLanes-1:0] alu_res;
  // Bytes still to issue, and bytes of this beat (k)
  vlen_t               bytes_left;
  vlen_t               beat_bytes;
  vaddr_t              beat_idx;

  // All lanes must present A and M, and the queue needs room
  assign beat_join = issue.issue_valid && (&opnd_a_valid_i) && (&opnd_m_valid_i) &&
                     !queue_full_i;

  assign issue.beat_fire = beat_join;
  assign push_o          = beat_join;
  // One ready per lane, acknowledges A and M together
  assign opnd_ready_o    = {NrLanes{beat_join}};

  // Mask ALU, applied to every lane at once
  always_comb begin
    case (issue.insn.op)
      VMANDNOT: alu_res = ~opnd_a_i & opnd_m_i;
      VMAND:    alu_res = opnd_a_i & opnd_m_i;
      VMOR:     alu_res = opnd_a_i | opnd_m_i;
      VMXOR:    alu_res = opnd_a_i ^ opnd_m_i;
      VMORNOT:  alu_res = ~opnd_a_i | opnd_m_i;
      VMNAND:   alu_res = ~(opnd_a_i & opnd_m_i);
      VMNOR:    alu_res = ~(opnd_a_i | opnd_m_i);
      VMXNOR:   alu_res = ~(opnd_a_i ^ opnd_m_i);
      default:  alu_res = '0;
    endcase
  end

  // vl is a multiple of 8, so the byte count is exact
  assign bytes_left = issue.issue_rem >> 3;
  assign beat_bytes = (bytes_left > vlen_t'(BeatBytes)) ? vlen_t'(BeatBytes) : bytes_left;
  // Beats already issued for this instruction
  assign beat_idx   = vaddr_t'((issue.insn.vl - issue.issue_rem) / BeatBits);

  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    vlen_t lane_bytes;

    // Even share per lane, low lanes take the remainder
    assign lane_bytes = vlen_t'(beat_bytes / NrLanes) + vlen_t'(l < (beat_bytes % NrLanes));

    assign payload_o[l] = '{
      id:    issue.insn.id,
      addr:  issue.insn.vd + beat_idx,
      wdata: alu_res[l],
      be:    strb_t'((1 << lane_bytes) - 1)
    };
  end : gen_lane

endmodule : mask_beat_gen

// File: hdl/mask_insn_ctrl.sv
module mask_insn_ctrl import mask_lane_pkg::*; import mask_insn_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  // Sequencer side
  input  mask_insn_t pe_req_i,
  input  logic       pe_req_valid_i,
  output logic       pe_req_ready_o,
  // Towards the beat generator
  mask_issue_if.ctrl issue,
  // From the result queue
  input  logic       beat_retired_i,
  // Completion response
  output logic       done_o,
  output vid_t       done_id_o
);

  // Mask bits covered by one full beat over all lanes
  localparam vlen_t BeatBits = vlen_t'(NrLanes * ElenWidth);

  // Slot occupied from acceptance until the cycle after done
  logic       busy_q;
  mask_insn_t insn_q;
  // Remaining bits on the issue and on the commit side
  vlen_t      issue_cnt_q;
  vlen_t      commit_cnt_q;
  logic       done_q;
  vid_t       done_id_q;

  logic       accept;
  logic       last_retire;

  // Only one instruction at a time
  assign pe_req_ready_o = !busy_q;
  assign accept         = pe_req_valid_i && !busy_q;

  // Retire that takes the commit counter down to zero
  assign last_retire = beat_retired_i && (commit_cnt_q != '0) &&
                       (commit_cnt_q <= BeatBits);

  // Issue side closes once every bit has been handed out
  assign issue.issue_valid = busy_q && (issue_cnt_q != '0);
  assign issue.insn        = insn_q;
  assign issue.issue_rem   = issue_cnt_q;

  assign done_o    = done_q;
  assign done_id_o = done_id_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q       <= 1'b0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      done_q       <= 1'b0;
    end else begin
      // Registered done, one cycle after the last retire
      done_q <= last_retire;
      if (accept) begin
        busy_q       <= 1'b1;
        issue_cnt_q  <= pe_req_i.vl;
        commit_cnt_q <= pe_req_i.vl;
      end else begin
        // Slot frees after the done pulse, so ready rises one cycle later
        if (done_q) begin
          busy_q <= 1'b0;
        end
        // Both counters saturate at zero on a short tail beat
        if (issue.beat_fire) begin
          issue_cnt_q <= (issue_cnt_q > BeatBits) ? issue_cnt_q - BeatBits : '0;
        end
        if (beat_retired_i) begin
          commit_cnt_q <= (commit_cnt_q > BeatBits) ? commit_cnt_q - BeatBits : '0;
        end
      end
    end
  end

  // Instruction fields and the done id
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q <= pe_req_i;
    end
    if (last_retire) begin
      done_id_q <= insn_q.id;
    end
  end

endmodule : mask_insn_ctrl

// File: hdl/mask_insn_pkg.sv
package mask_insn_pkg;

  // Register address and id types come from the lane side
  import mask_lane_pkg::*;

  // Mask-logical opcodes
  typedef enum logic [2:0] {
    VMANDNOT = 3'd0,
    VMAND    = 3'd1,
    VMOR     = 3'd2,
    VMXOR    = 3'd3,
    VMORNOT  = 3'd4,
    VMNAND   = 3'd5,
    VMNOR    = 3'd6,
    VMXNOR   = 3'd7
  } mask_op_e;

  // Vector length counted in mask bits
  typedef logic [11:0] vlen_t;

  // Instruction as issued by the sequencer
  // vl is expected to be a multiple of 8
  typedef struct packed {
    mask_op_e op;
    vaddr_t   vd;
    vlen_t    vl;
    vid_t     id;
  } mask_insn_t;

endpackage : mask_insn_pkg

// File: hdl/mask_issue_if.sv
interface mask_issue_if import mask_insn_pkg::*; ();

  // Instruction in the issue phase
  logic       issue_valid;
  mask_insn_t insn;
  // Mask bits that are still to be issued
  vlen_t      issue_rem;
  // High in the cycle a beat is consumed
  logic       beat_fire;

  // Control side owns the instruction slot
  modport ctrl (
    output issue_valid,
    output insn,
    output issue_rem,
    input  beat_fire
  );

  // Beat generator consumes beats
  modport gen (
    input  issue_valid,
    input  insn,
    input  issue_rem,
    output beat_fire
  );

endinterface : mask_issue_if

// File: hdl/mask_lane_pkg.sv
package mask_lane_pkg;

  // Width of one lane word in bits
  localparam int unsigned ElenWidth = 16;
  // Bytes per lane word
  localparam int unsigned StrbWidth = ElenWidth / 8;

  // One lane word
  typedef logic [ElenWidth-1:0] elen_t;
  // Byte enable of one lane word
  typedef logic [StrbWidth-1:0] strb_t;
  // Word address inside the lane register file
  typedef logic [7:0] vaddr_t;
  // Instruction id, also used on the result channel
  typedef logic [2:0] vid_t;

  // Result of one lane for one beat
  // Field order matches the write-back bus, 29 bits in total
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } payload_t;

endpackage : mask_lane_pkg

// File: hdl/mask_result_queue.sv
module mask_result_queue import mask_lane_pkg::*; #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // From the beat generator
  input  logic                   push_i,
  input  payload_t [NrLanes-1:0] payload_i,
  output logic                   full_o,
  // To the control
  output logic                   beat_retired_o,
  // Write-back to the lanes
  output logic     [NrLanes-1:0] result_req_o,
  output vaddr_t   [NrLanes-1:0] result_addr_o,
  output vid_t     [NrLanes-1:0] result_id_o,
  output elen_t    [NrLanes-1:0] result_wdata_o,
  output strb_t    [NrLanes-1:0] result_be_o,
  input  logic     [NrLanes-1:0] result_gnt_i
);

  localparam int unsigned PtrWidth = (ResultQueueDepth > 1) ? $clog2(ResultQueueDepth) : 1;
  localparam int unsigned CntWidth = $clog2(ResultQueueDepth + 1);

  payload_t [ResultQueueDepth-1:0][NrLanes-1:0] mem_q;
  // One pending bit per lane and entry
  logic     [ResultQueueDepth-1:0][NrLanes-1:0] valid_q;
  logic     [PtrWidth-1:0]                      wr_ptr_q;
  logic     [PtrWidth-1:0]                      rd_ptr_q;
  logic     [CntWidth-1:0]                      cnt_q;

  // Head lanes still waiting after this cycle's grants
  logic     [NrLanes-1:0]                       head_left;
  logic                                         pop;

  assign full_o    = (cnt_q == CntWidth'(ResultQueueDepth));
  assign head_left = valid_q[rd_ptr_q] & ~result_gnt_i;
  // Pop in the cycle the last outstanding lane is granted
  assign pop       = (cnt_q != '0) && (head_left == '0);

  assign beat_retired_o = pop;

  // Head entry drives the lanes directly
  assign result_req_o = valid_q[rd_ptr_q];
  for (genvar l = 0; l < NrLanes; l++) begin : gen_out
    assign result_addr_o[l]  = mem_q[rd_ptr_q][l].addr;
    assign result_id_o[l]    = mem_q[rd_ptr_q][l].id;
    assign result_wdata_o[l] = mem_q[rd_ptr_q][l].wdata;
    assign result_be_o[l]    = mem_q[rd_ptr_q][l].be;
  end : gen_out

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // Granted lanes drop their request
      valid_q[rd_ptr_q] <= head_left;
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrWidth'(ResultQueueDepth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // New beat requests on every lane
      if (push_i) begin
        valid_q[wr_ptr_q] <= '1;
        wr_ptr_q <= (wr_ptr_q == PtrWidth'(ResultQueueDepth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      cnt_q <= cnt_q + CntWidth'(push_i) - CntWidth'(pop);
    end
  end

  // Entry storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= payload_i;
    end
  end

endmodule : mask_result_queue

// File: hdl/masku_top.sv
module masku_top import mask_lane_pkg::*; import mask_insn_pkg::*; #(
  parameter int unsigned NrLanes          = 2,
  parameter int unsigned ResultQueueDepth = 2
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Sequencer
  input  mask_insn_t           pe_req_i,
  input  logic                 pe_req_valid_i,
  output logic                 pe_req_ready_o,
  // Operand channels A and M
  input  elen_t  [NrLanes-1:0] opnd_a_i,
  input  elen_t  [NrLanes-1:0] opnd_m_i,
  input  logic   [NrLanes-1:0] opnd_a_valid_i,
  input  logic   [NrLanes-1:0] opnd_m_valid_i,
  output logic   [NrLanes-1:0] opnd_ready_o,
  // Result write-back
  output logic   [NrLanes-1:0] result_req_o,
  output vaddr_t [NrLanes-1:0] result_addr_o,
  output vid_t   [NrLanes-1:0] result_id_o,
  output elen_t  [NrLanes-1:0] result_wdata_o,
  output strb_t  [NrLanes-1:0] result_be_o,
  input  logic   [NrLanes-1:0] result_gnt_i,
  // Completion
  output logic                 done_o,
  output vid_t                 done_id_o
);

  mask_issue_if issue_if ();

  logic                   beat_retired;
  logic                   queue_full;
  logic                   push;
  payload_t [NrLanes-1:0] payload;

  // Instruction slot and bit counters
  mask_insn_ctrl #(
    .NrLanes(NrLanes)
  ) i_ctrl (
    .clk_i,
    .rst_ni,
    .pe_req_i,
    .pe_req_valid_i,
    .pe_req_ready_o,
    .issue         (issue_if.ctrl),
    .beat_retired_i(beat_retired),
    .done_o,
    .done_id_o
  );

  // Operand join and mask ALU
  mask_beat_gen #(
    .NrLanes(NrLanes)
  ) i_beat_gen (
    .issue         (issue_if.gen),
    .opnd_a_i,
    .opnd_m_i,
    .opnd_a_valid_i,
    .opnd_m_valid_i,
    .opnd_ready_o,
    .queue_full_i  (queue_full),
    .push_o        (push),
    .payload_o     (payload)
  );

  // Per-lane write-back
  mask_result_queue #(
    .NrLanes         (NrLanes),
    .ResultQueueDepth(ResultQueueDepth)
  ) i_result_queue (
    .clk_i,
    .rst_ni,
    .push_i        (push),
    .payload_i     (payload),
    .full_o        (queue_full),
    .beat_retired_o(beat_retired),
    .result_req_o,
    .result_addr_o,
    .result_id_o,
    .result_wdata_o,
    .result_be_o,
    .result_gnt_i
  );

endmodule : masku_top

// File: sources.f
hdl/mask_lane_pkg.sv
hdl/mask_insn_pkg.sv
hdl/mask_issue_if.sv
hdl/mask_insn_ctrl.sv
hdl/mask_beat_gen.sv
hdl/mask_result_queue.sv
hdl/masku_top.sv
testbench/masku_props.sv
testbench/masku_tb.sv

// File: testbench/masku_props.sv
module masku_props import mask_lane_pkg::*; #(
  parameter int unsigned NrLanes = 2
) (
  input logic                 clk_i,
  input logic                 rst_ni,
  input logic                 pe_req_valid_i,
  input logic                 pe_req_ready_o,
  input logic   [NrLanes-1:0] opnd_a_valid_i,
  input logic   [NrLanes-1:0] opnd_m_valid_i,
  input logic   [NrLanes-1:0] opnd_ready_o,
  input logic   [NrLanes-1:0] result_req_o,
  input vaddr_t [NrLanes-1:0] result_addr_o,
  input vid_t   [NrLanes-1:0] result_id_o,
  input elen_t  [NrLanes-1:0] result_wdata_o,
  input strb_t  [NrLanes-1:0] result_be_o,
  input logic   [NrLanes-1:0] result_gnt_i,
  input logic                 done_o
);

  // Failed assertions, summed into the testbench error count
  int unsigned fail_count = 0;

  // Request and payload held on every lane until its grant
  for (genvar l = 0; l < NrLanes; l++) begin : gen_lane
    a_req_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      result_req_o[l] && !result_gnt_i[l] |=> result_req_o[l] &&
      $stable(result_addr_o[l]) && $stable(result_id_o[l]) &&
      $stable(result_wdata_o[l]) && $stable(result_be_o[l]))
    else begin
      $error("Lane %0d dropped or changed its request before the grant", l);
      fail_count++;
    end
  end : gen_lane

  // Lanes acknowledge operands together and only when every lane presents A and M
  a_ready_all: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (opnd_ready_o != '0) |-> (opnd_ready_o == '1) && (&opnd_a_valid_i) && (&opnd_m_valid_i))
  else begin
    $error("Operand ready differs between lanes or came without all operands");
    fail_count++;
  end

  a_done_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) done_o |=> !done_o)
  else begin
    $error("Done held high for two cycles");
    fail_count++;
  end

  // Acceptance closes the slot, and only a done pulse reopens it
  a_accept_busy: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_i && pe_req_ready_o |=> !pe_req_ready_o)
  else begin
    $error("Instruction ready stayed high after acceptance");
    fail_count++;
  end

  a_ready_rise: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(pe_req_ready_o) |-> $past(done_o))
  else begin
    $error("Instruction ready rose without a preceding done pulse");
    fail_count++;
  end

endmodule : masku_props

bind masku_top masku_props #(.NrLanes(NrLanes)) i_props (.*);

// File: testbench/masku_tb.sv
module masku_tb import mask_lane_pkg::*; import mask_insn_pkg::*; ();

  localparam int unsigned NrLanes    = 2;
  localparam int unsigned QueueDepth = 2;
  localparam int unsigned NumInsn    = 8;
  localparam int unsigned BeatBits   = NrLanes * ElenWidth;
  localparam int unsigned BeatBytes  = NrLanes * StrbWidth;

  // Columns: op, vd, vl in bits, id
  localparam mask_insn_t InsnTable [NumInsn] = '{
    '{VMANDNOT, 8'h10, 12'd96,  3'd1},
    '{VMAND,    8'h20, 12'd24,  3'd2},
    '{VMOR,     8'h30, 12'd40,  3'd3},
    '{VMXOR,    8'h40, 12'd32,  3'd4},
    '{VMORNOT,  8'hfe, 12'd64,  3'd5},
    '{VMNAND,   8'h50, 12'd8,   3'd6},
    '{VMNOR,    8'h60, 12'd128, 3'd7},
    '{VMXNOR,   8'h70, 12'd56,  3'd0}
  };

  logic                 clk_i;
  logic                 rst_ni;
  mask_insn_t           pe_req_i;
  logic                 pe_req_valid_i;
  logic                 pe_req_ready_o;
  elen_t  [NrLanes-1:0] opnd_a_i;
  elen_t  [NrLanes-1:0] opnd_m_i;
  logic   [NrLanes-1:0] opnd_a_valid_i;
  logic   [NrLanes-1:0] opnd_m_valid_i;
  logic   [NrLanes-1:0] opnd_ready_o;
  logic   [NrLanes-1:0] result_req_o;
  vaddr_t [NrLanes-1:0] result_addr_o;
  vid_t   [NrLanes-1:0] result_id_o;
  elen_t  [NrLanes-1:0] result_wdata_o;
  strb_t  [NrLanes-1:0] result_be_o;
  logic   [NrLanes-1:0] result_gnt_i;
  logic                 done_o;
  vid_t                 done_id_o;

  // Expected payloads per lane, in write-back order
  payload_t    exp_q [NrLanes][$];
  // Reference model state of the running instruction
  mask_insn_t  cur_insn;
  vlen_t       model_rem;
  vaddr_t      model_beat;
  int unsigned errors;
  int unsigned done_cnt;
  int unsigned cycles;
  int unsigned cycle_limit;
  int unsigned seed_val;

  masku_top #(.NrLanes(NrLanes), .ResultQueueDepth(QueueDepth)) DUT (.*);

  always #20 clk_i = ~clk_i;

  function automatic elen_t mask_op_ref(mask_op_e op, elen_t a, elen_t m);
    case (op)
      VMANDNOT: return ~a & m;
      VMAND:    return a & m;
      VMOR:     return a | m;
      VMXOR:    return a ^ m;
      VMORNOT:  return ~a | m;
      VMNAND:   return ~(a & m);
      VMNOR:    return ~(a | m);
      VMXNOR:   return ~(a ^ m);
      default:  return '0;
    endcase
  endfunction

  task automatic check_payload(string name, payload_t got, payload_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t %s got %h exp %h", $time, name, got, exp);
    end
  endtask

  task automatic check_done(vid_t got, vid_t exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t done_id_o got %h exp %h", $time, got, exp);
    end
  endtask

  task automatic check_lanes(string name, logic [NrLanes-1:0] got, logic [NrLanes-1:0] exp);
    if (got !== exp) begin
      errors++;
      $display("MISMATCH %0t %s got %b exp %b", $time, name, got, exp);
    end
  endtask

  // Expected payload of every lane for one consumed beat
  task automatic record_beat();
    int unsigned k;
    int unsigned nbytes;
    payload_t    exp;
    k = (model_rem / 8 > BeatBytes) ? BeatBytes : model_rem / 8;
    for (int l = 0; l < NrLanes; l++) begin
      // Low lanes take the odd byte
      nbytes = k / NrLanes + ((l < k % NrLanes) ? 1 : 0);
      exp.id    = cur_insn.id;
      exp.addr  = cur_insn.vd + model_beat;
      exp.wdata = mask_op_ref(cur_insn.op, opnd_a_i[l], opnd_m_i[l]);
      exp.be    = '0;
      for (int b = 0; b < nbytes; b++) begin
        exp.be[b] = 1'b1;
      end
      exp_q[l].push_back(exp);
    end
    model_rem  = (model_rem > BeatBits) ? model_rem - BeatBits : '0;
    model_beat = model_beat + 1'b1;
  endtask

  // Granted lanes are compared against the model in order
  task automatic collect_results();
    payload_t got;
    for (int l = 0; l < NrLanes; l++) begin
      if (result_req_o[l] && result_gnt_i[l]) begin
        got = '{id: result_id_o[l], addr: result_addr_o[l], wdata: result_wdata_o[l],
                be: result_be_o[l]};
        if (exp_q[l].size() == 0) begin
          errors++;
          $display("Lane %0d wrote a result at %0t that was not expected", l, $time);
        end else begin
          check_payload($sformatf("result_payload[%0d]", l), got, exp_q[l].pop_front());
        end
      end
    end
  endtask

  // Lane responders, model hook and timeout
  always @(posedge clk_i) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
      $display("TEST FAILED");
      $finish;
    end else if (rst_ni) begin
      if (opnd_ready_o != '0) begin
        record_beat();
      end
      collect_results();
      if (done_o) begin
        done_cnt++;
      end
      result_gnt_i <= NrLanes'($urandom);
      // New operands only after the lane's ready
      for (int l = 0; l < NrLanes; l++) begin
        if (opnd_ready_o[l]) begin
          opnd_a_i[l]       <= elen_t'($urandom);
          opnd_m_i[l]       <= elen_t'($urandom);
          // A lane sometimes pauses before it presents the next word
          opnd_a_valid_i[l] <= ($urandom % 4) != 0;
          opnd_m_valid_i[l] <= ($urandom % 4) != 0;
        end else begin
          // Presented words stay valid until the lane's ready
          opnd_a_valid_i[l] <= 1'b1;
          opnd_m_valid_i[l] <= 1'b1;
        end
      end
    end
  end

  initial begin
    int unsigned total_beats;
    seed_val    = $urandom(32'h25bd_162a);
    total_beats = 0;
    for (int n = 0; n < NumInsn; n++) begin
      total_beats += (InsnTable[n].vl + BeatBits - 1) / BeatBits;
    end
    cycle_limit    = total_beats * 40 + 200;
    errors         = 0;
    done_cnt       = 0;
    cycles         = 0;
    clk_i          = 1'b0;
    rst_ni         = 1'b0;
    pe_req_i       = '0;
    pe_req_valid_i = 1'b0;
    opnd_a_i       = {elen_t'($urandom), elen_t'($urandom)};
    opnd_m_i       = {elen_t'($urandom), elen_t'($urandom)};
    // Operands offered from the start, the DUT joins them only while issuing
    opnd_a_valid_i = '1;
    opnd_m_valid_i = '1;
    result_gnt_i   = '0;
    cur_insn       = '0;
    model_rem      = '0;
    model_beat     = '0;
    repeat (16) @(posedge clk_i);
    // Idle outputs in reset
    check_lanes("pe_req_ready_o", {NrLanes{pe_req_ready_o}}, '1);
    check_lanes("result_req_o", result_req_o, '0);
    check_lanes("opnd_ready_o", opnd_ready_o, '0);
    check_lanes("done_o", {NrLanes{done_o}}, '0);
    rst_ni <= 1'b1;
    for (int n = 0; n < NumInsn; n++) begin
      pe_req_i       <= InsnTable[n];
      pe_req_valid_i <= 1'b1;
      @(posedge clk_i);
      while (!pe_req_ready_o) begin
        @(posedge clk_i);
      end
      pe_req_valid_i <= 1'b0;
      cur_insn   = InsnTable[n];
      model_rem  = InsnTable[n].vl;
      model_beat = '0;
      @(posedge clk_i);
      while (!done_o) begin
        @(posedge clk_i);
      end
      check_done(done_id_o, InsnTable[n].id);
      // Every beat must be issued and written before done
      if (model_rem != 0 || exp_q[0].size() != 0 || exp_q[1].size() != 0) begin
        errors++;
        $display("Done for id %0d came before all beats were written", InsnTable[n].id);
      end
    end
    repeat (4) @(posedge clk_i);
    if (done_cnt != NumInsn) begin
      errors++;
      $display("Expected %0d done pulses but saw %0d", NumInsn, done_cnt);
    end
    errors += DUT.i_props.fail_count;
    $display("Checks finished with %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule : masku_tb
